// ==== sources.f ====
src/fetch_pkg.sv
src/fetch_attr_fifo.sv
src/scratch_fetch_unit.sv
src/bus_fetch_unit.sv
src/fetch_control_regs.sv
src/fetch.sv
src/fetch_top.sv
dv/fetch_tb.sv

// ==== Makefile ====
TOP = fetch_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;

    localparam int          FIFO_DEPTH    = 2;
    localparam int          SCRATCH_WORDS = 256;
    localparam logic [31:0] SEED          = 32'd19083;

    logic                 clk;
    logic                 flush_or_rst;
    logic                 id_available;
    logic                 cfg_req;
    fetch_pkg::cfg_addr_t cfg_addr;
    fetch_pkg::addr_t     cfg_wdata;
    logic                 cfg_ack;
    logic                 mem_req;
    fetch_pkg::addr_t     mem_addr;
    logic                 mem_ack;
    fetch_pkg::instr_t    mem_rdata;
    logic                 fetch_complete;
    fetch_pkg::addr_t     fetch_pc;
    fetch_pkg::instr_t    fetch_instruction;
    logic                 fetch_fault;

    // Reference model
    fetch_pkg::instr_t scratch_mirror [SCRATCH_WORDS];
    fetch_pkg::addr_t  expected_pc      = fetch_pkg::RESET_VEC;
    fetch_pkg::addr_t  redirect_target  = fetch_pkg::RESET_VEC;
    int                redirect_count   = 0;
    int                redirects_taken  = 0;
    logic              fault_seen       = 1'b0;
    logic              ack_seen         = 1'b0;
    int                done_count       = 0;
    int                credit_mode      = 0;
    int                value_errors     = 0;
    int                other_errors     = 0;
    int                responder_errors = 0;

    fetch_top #(
        .FIFO_DEPTH   (FIFO_DEPTH),
        .SCRATCH_WORDS(SCRATCH_WORDS)
    ) UUT (
        .clk(clk), .flush_or_rst(flush_or_rst), .id_available(id_available),
        .cfg_req(cfg_req), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_ack(cfg_ack),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
        .fetch_complete(fetch_complete), .fetch_pc(fetch_pc),
        .fetch_instruction(fetch_instruction), .fetch_fault(fetch_fault)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Model functions

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Word the memory responder returns for an address
    function automatic fetch_pkg::instr_t mem_hash(input fetch_pkg::addr_t a);
        return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic logic in_region(input fetch_pkg::addr_t a, input fetch_pkg::addr_t base,
                                       input int bits);
        return (a >> (32 - bits)) == (base >> (32 - bits));
    endfunction

    function automatic logic is_mapped(input fetch_pkg::addr_t a);
        return in_region(a, fetch_pkg::SCRATCH_BASE, fetch_pkg::SCRATCH_CHECK_BITS) ||
               in_region(a, fetch_pkg::MEMORY_BASE, fetch_pkg::MEMORY_CHECK_BITS);
    endfunction

    function automatic fetch_pkg::instr_t expected_word(input fetch_pkg::addr_t pc);
        fetch_pkg::addr_t offset;
        offset = (pc - fetch_pkg::SCRATCH_BASE) >> 2;
        if (in_region(pc, fetch_pkg::SCRATCH_BASE, fetch_pkg::SCRATCH_CHECK_BITS))
            return scratch_mirror[offset[$clog2(SCRATCH_WORDS)-1:0]];
        else if (in_region(pc, fetch_pkg::MEMORY_BASE, fetch_pkg::MEMORY_CHECK_BITS))
            return mem_hash(pc);
        else
            return '0;
    endfunction

    ////////////////////////////////////////////////////////////
    // Checks

    task automatic check_addr(input string what, input fetch_pkg::addr_t got,
                              input fetch_pkg::addr_t want);
        if (got !== want) begin
            value_errors++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_instr(input string what, input fetch_pkg::instr_t got,
                               input fetch_pkg::instr_t want);
        if (got !== want) begin
            value_errors++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic want);
        if (got !== want) begin
            value_errors++;
            $display("Error at %0d ns: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("Failure at %0d ns: %s", $time, what);
    endtask

    // Completions are sampled mid-cycle, away from both edges
    always @(negedge clk) begin : completion_monitor
        if (flush_or_rst !== 1'b1) begin
            // New stream starts on the edge that raises cfg_ack
            if (cfg_ack && !ack_seen && redirect_count != redirects_taken) begin
                expected_pc     = redirect_target;
                fault_seen      = 1'b0;
                redirects_taken = redirect_count;
            end
            ack_seen = cfg_ack;
            if (fetch_complete) begin
                if (fault_seen)
                    report_failure("fetch completed after an access fault");
                check_addr("fetch_pc", fetch_pc, expected_pc);
                check_bit("fetch_fault", fetch_fault, !is_mapped(expected_pc));
                check_instr("fetch_instruction", fetch_instruction, expected_word(expected_pc));
                fault_seen  = !is_mapped(expected_pc);
                expected_pc = expected_pc + 32'd4;
                done_count++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Issue credit and memory responder

    initial begin : credit_driver
        logic [31:0] rng;
        rng          = xorshift(SEED);
        id_available = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            rng = xorshift(rng);
            if (credit_mode == 0)
                id_available = 1'b0;
            else if (credit_mode == 1)
                id_available = 1'b1;
            else
                id_available = rng[0] | rng[1];
        end
    end

    initial begin : memory_responder
        logic [31:0] rng;
        int          delay;
        int          cycles;
        rng       = xorshift(xorshift(SEED));
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_req === 1'b1) begin
                rng   = xorshift(rng);
                delay = int'(rng % 32'd6);
                for (int i = 0; i < delay; i++) begin
                    @(posedge clk);
                    #1;
                end
                mem_ack   = 1'b1;
                mem_rdata = mem_hash(mem_addr);
                cycles    = 0;
                while (mem_req === 1'b1 && cycles < 50) begin
                    @(posedge clk);
                    #1;
                    cycles++;
                end
                if (mem_req === 1'b1) begin
                    responder_errors++;
                    $display("Failure at %0d ns: mem_req stayed high after mem_ack", $time);
                end
                mem_ack = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus tasks, all entered 1 ns after a rising edge

    task automatic pause(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic cfg_write(input fetch_pkg::cfg_addr_t addr, input fetch_pkg::addr_t data);
        int cycles;
        cfg_req   = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        cycles    = 0;
        while (cfg_ack !== 1'b1 && cycles < 20) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (cfg_ack !== 1'b1)
            report_failure("cfg_ack never rose for a configuration write");
        cfg_req = 1'b0;
        cycles  = 0;
        while (cfg_ack !== 1'b0 && cycles < 20) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (cfg_ack !== 1'b0)
            report_failure("cfg_ack never dropped after cfg_req went low");
    endtask

    task automatic redirect_to(input fetch_pkg::addr_t target);
        redirect_target = target;
        redirect_count++;
        cfg_write(fetch_pkg::CFG_REDIRECT, target);
    endtask

    task automatic wait_completions(input int count);
        int target;
        int cycles;
        target = done_count + count;
        cycles = 0;
        while (done_count < target && cycles < 2000) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (done_count < target)
            report_failure("expected fetch completions did not arrive");
    endtask

    task automatic wait_bus_request();
        int cycles;
        cycles = 0;
        while (mem_req !== 1'b1 && cycles < 200) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (mem_req !== 1'b1)
            report_failure("no bus request while fetching from external memory");
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence

    initial begin : stimulus
        logic [31:0]       rng;
        fetch_pkg::addr_t  target;
        fetch_pkg::instr_t word;
        int                snapshot;

        rng          = SEED;
        flush_or_rst = 1'b1;
        cfg_req      = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        credit_mode  = 0;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
        end
        #1;
        flush_or_rst = 1'b0;

        // Scratch load and readback
        cfg_write(fetch_pkg::CFG_SCRATCH_ADDR, 32'd0);
        for (int i = 0; i < SCRATCH_WORDS; i++) begin
            rng               = xorshift(rng);
            word              = rng;
            scratch_mirror[i] = word;
            cfg_write(fetch_pkg::CFG_SCRATCH_DATA, word);
        end
        redirect_to(fetch_pkg::RESET_VEC);
        credit_mode = 1;
        wait_completions(40);

        // Bus fetch under random ack delays
        redirect_to({fetch_pkg::MEMORY_BASE[31:12], 12'h100});
        wait_completions(20);

        // Back-pressure and hold, once per region
        credit_mode = 2;
        for (int k = 0; k < 2; k++) begin
            redirect_to(k == 0 ? {fetch_pkg::RESET_VEC[31:12], 12'h200}
                                : {fetch_pkg::MEMORY_BASE[31:12], 12'h800});
            wait_completions(25);
            cfg_write(fetch_pkg::CFG_HOLD, 32'd1);
            pause(20);
            snapshot = done_count;
            pause(10);
            if (done_count != snapshot)
                report_failure("fetch kept completing while the hold bit was set");
            cfg_write(fetch_pkg::CFG_HOLD, 32'd0);
            wait_completions(15);
        end

        // Redirects at random points, some during an open bus handshake
        for (int k = 0; k < 12; k++) begin
            rng = xorshift(rng);
            if (rng[0])
                target = {fetch_pkg::RESET_VEC[31:8], rng[7:2], 2'b00};
            else
                target = {fetch_pkg::MEMORY_BASE[31:16], rng[17:4], 2'b00};
            redirect_to(target);
            wait_completions(int'(rng[3:2]) + 2);
            if (!rng[0] && rng[1])
                wait_bus_request();
            else
                pause(int'(rng[26:24]));
        end

        // Access fault, then resume
        credit_mode = 1;
        redirect_to(32'h0000_2000);
        wait_completions(1);
        pause(25);
        redirect_to(fetch_pkg::RESET_VEC);
        wait_completions(10);

        $display("Run finished: %0d completions, %0d value errors, %0d other failures",
                 done_count, value_errors, other_errors + responder_errors);
        if (value_errors == 0 && other_errors == 0 && responder_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== src/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top #(
    parameter int FIFO_DEPTH    = 2,
    parameter int SCRATCH_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 flush_or_rst,
    input  logic                 id_available,

    input  logic                 cfg_req,
    input  fetch_pkg::cfg_addr_t cfg_addr,
    input  fetch_pkg::addr_t     cfg_wdata,
    output logic                 cfg_ack,

    output logic                 mem_req,
    output fetch_pkg::addr_t     mem_addr,
    input  logic                 mem_ack,
    input  fetch_pkg::instr_t    mem_rdata,

    output logic                 fetch_complete,
    output fetch_pkg::addr_t     fetch_pc,
    output fetch_pkg::instr_t    fetch_instruction,
    output logic                 fetch_fault
);

    logic                             hold;
    logic                             redirect;
    fetch_pkg::addr_t                 redirect_pc;
    logic                             scratch_we;
    logic [$clog2(SCRATCH_WORDS)-1:0] scratch_waddr;
    fetch_pkg::instr_t                scratch_wdata;

    logic [1:0]                       unit_new_request;
    fetch_pkg::addr_t                 unit_addr [2];
    logic [1:0]                       unit_flush;
    logic [1:0]                       unit_ready;
    logic [1:0]                       unit_data_valid;
    fetch_pkg::instr_t                unit_data [2];

    fetch_control_regs #(.SCRATCH_WORDS(SCRATCH_WORDS)) control_regs (
        .clk(clk), .flush_or_rst(flush_or_rst),
        .cfg_req(cfg_req), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_ack(cfg_ack),
        .hold(hold), .redirect(redirect), .redirect_pc(redirect_pc),
        .scratch_we(scratch_we), .scratch_waddr(scratch_waddr),
        .scratch_wdata(scratch_wdata)
    );

    fetch #(.FIFO_DEPTH(FIFO_DEPTH)) fetch_core (
        .clk(clk), .flush_or_rst(flush_or_rst), .id_available(id_available),
        .hold(hold), .redirect(redirect), .redirect_pc(redirect_pc),
        .unit_new_request(unit_new_request), .unit_addr(unit_addr),
        .unit_flush(unit_flush), .unit_ready(unit_ready),
        .unit_data_valid(unit_data_valid), .unit_data(unit_data),
        .fetch_complete(fetch_complete), .fetch_pc(fetch_pc),
        .fetch_instruction(fetch_instruction), .fetch_fault(fetch_fault)
    );

    scratch_fetch_unit #(.SCRATCH_WORDS(SCRATCH_WORDS)) scratch_unit (
        .clk(clk), .flush_or_rst(unit_flush[fetch_pkg::SCRATCH_ID]),
        .new_request(unit_new_request[fetch_pkg::SCRATCH_ID]),
        .addr(unit_addr[fetch_pkg::SCRATCH_ID]),
        .ready(unit_ready[fetch_pkg::SCRATCH_ID]),
        .data_valid(unit_data_valid[fetch_pkg::SCRATCH_ID]),
        .data(unit_data[fetch_pkg::SCRATCH_ID]),
        .scratch_we(scratch_we), .scratch_waddr(scratch_waddr),
        .scratch_wdata(scratch_wdata)
    );

    bus_fetch_unit bus_unit (
        .clk(clk), .flush_or_rst(unit_flush[fetch_pkg::BUS_ID]),
        .new_request(unit_new_request[fetch_pkg::BUS_ID]),
        .addr(unit_addr[fetch_pkg::BUS_ID]),
        .ready(unit_ready[fetch_pkg::BUS_ID]),
        .data_valid(unit_data_valid[fetch_pkg::BUS_ID]),
        .data(unit_data[fetch_pkg::BUS_ID]),
        .mem_req(mem_req), .mem_addr(mem_addr),
        .mem_ack(mem_ack), .mem_rdata(mem_rdata)
    );

endmodule

// ==== src/fetch.sv ====
`timescale 1ns/1ps

module fetch #(
    parameter int FIFO_DEPTH = 2
) (
    input  logic              clk,
    input  logic              flush_or_rst,

    // Steering
    input  logic              id_available,
    input  logic              hold,
    input  logic              redirect,
    input  fetch_pkg::addr_t  redirect_pc,

    // Sub-units, indexed by unit_id_t
    output logic [1:0]        unit_new_request,
    output fetch_pkg::addr_t  unit_addr [2],
    output logic [1:0]        unit_flush,
    input  logic [1:0]        unit_ready,
    input  logic [1:0]        unit_data_valid,
    input  fetch_pkg::instr_t unit_data [2],

    // Result
    output logic              fetch_complete,
    output fetch_pkg::addr_t  fetch_pc,
    output fetch_pkg::instr_t fetch_instruction,
    output logic              fetch_fault
);

    // Entry layout: {unit id, fault, pc}
    localparam int PC_W   = $bits(fetch_pkg::addr_t);
    localparam int ATTR_W = $bits(fetch_pkg::unit_id_t) + 1 + PC_W;

    fetch_pkg::addr_t      pc;
    logic [1:0]            unit_hit;
    logic                  mapped;
    fetch_pkg::unit_id_t   unit_sel;
    logic                  issue;
    logic                  fault_pending;
    logic                  attr_flush;
    logic                  attr_valid;
    logic                  attr_full;
    logic [ATTR_W-1:0]     attr_in;
    logic [ATTR_W-1:0]     attr_out;
    fetch_pkg::unit_id_t   head_unit;
    logic                  head_fault;

    ////////////////////////////////////////////////////////////
    // Region decode
    assign unit_hit[fetch_pkg::SCRATCH_ID] =
        pc[31:32-fetch_pkg::SCRATCH_CHECK_BITS] ==
        fetch_pkg::SCRATCH_BASE[31:32-fetch_pkg::SCRATCH_CHECK_BITS];
    assign unit_hit[fetch_pkg::BUS_ID] =
        pc[31:32-fetch_pkg::MEMORY_CHECK_BITS] ==
        fetch_pkg::MEMORY_BASE[31:32-fetch_pkg::MEMORY_CHECK_BITS];

    assign mapped   = |unit_hit;
    assign unit_sel = unit_hit[fetch_pkg::BUS_ID] ? fetch_pkg::BUS_ID : fetch_pkg::SCRATCH_ID;

    ////////////////////////////////////////////////////////////
    // Issue and PC
    // Nothing issues in the redirect cycle, the new stream starts after it
    assign issue = id_available & ~hold & ~fault_pending & (&unit_ready) &
                   ~attr_full & ~redirect;

    always_ff @(posedge clk) begin
        if (flush_or_rst)
            pc <= fetch_pkg::RESET_VEC;
        else if (redirect)
            pc <= {redirect_pc[31:2], 2'b00};
        else if (issue)
            pc <= pc + 32'd4;
    end

    // Fetch stalls after an unmapped PC until the next redirect
    always_ff @(posedge clk) begin
        if (flush_or_rst || redirect)
            fault_pending <= 1'b0;
        else if (issue && !mapped)
            fault_pending <= 1'b1;
    end

    for (genvar i = 0; i < 2; i++) begin : g_units
        assign unit_new_request[i] = issue & unit_hit[i];
        assign unit_addr[i]        = pc;
        assign unit_flush[i]       = flush_or_rst | redirect;
    end

    ////////////////////////////////////////////////////////////
    // In-flight attributes
    assign attr_flush = flush_or_rst | redirect;
    assign attr_in    = {unit_sel, ~mapped, pc};

    fetch_attr_fifo #(
        .DATA_WIDTH(ATTR_W),
        .DEPTH     (FIFO_DEPTH)
    ) attr_fifo (
        .clk         (clk),
        .flush_or_rst(attr_flush),
        .push        (issue),
        .pop         (fetch_complete),
        .data_in     (attr_in),
        .data_out    (attr_out),
        .valid       (attr_valid),
        .full        (attr_full)
    );

    assign head_unit  = attr_out[ATTR_W-1];
    assign head_fault = attr_out[PC_W];

    ////////////////////////////////////////////////////////////
    // Result
    // Faults complete at the head without waiting on a unit
    assign fetch_complete = attr_valid & ~redirect &
                            (head_fault | unit_data_valid[head_unit]);
    assign fetch_pc          = attr_out[PC_W-1:0];
    assign fetch_fault       = head_fault;
    assign fetch_instruction = head_fault ? '0 : unit_data[head_unit];

    no_spurious_data: assert property (@(posedge clk) disable iff (flush_or_rst)
        (|unit_data_valid) |->
            (attr_valid && !head_fault && unit_data_valid[head_unit] &&
             $onehot(unit_data_valid)))
        else $error("Sub-unit data without a matching FIFO head entry");

endmodule

// ==== src/fetch_control_regs.sv ====
`timescale 1ns/1ps

module fetch_control_regs #(
    parameter int SCRATCH_WORDS = 256
) (
    input  logic                             clk,
    input  logic                             flush_or_rst,

    // Configuration port, four-phase req/ack
    input  logic                             cfg_req,
    input  fetch_pkg::cfg_addr_t             cfg_addr,
    input  fetch_pkg::addr_t                 cfg_wdata,
    output logic                             cfg_ack,

    // Steering of fetch
    output logic                             hold,
    output logic                             redirect,
    output fetch_pkg::addr_t                 redirect_pc,

    // Scratch loading
    output logic                             scratch_we,
    output logic [$clog2(SCRATCH_WORDS)-1:0] scratch_waddr,
    output fetch_pkg::instr_t                scratch_wdata
);

    localparam int IDX_W = $clog2(SCRATCH_WORDS);

    typedef enum logic [1:0] {
        CFG_IDLE,
        CFG_ACKED,
        CFG_WAIT_DROP
    } cfg_state_t;

    cfg_state_t       state;
    logic             do_write;
    logic [IDX_W-1:0] scratch_idx;

    // The write happens on the edge that raises cfg_ack
    assign do_write = (state == CFG_IDLE) && cfg_req;
    assign cfg_ack  = (state != CFG_IDLE);

    always_ff @(posedge clk) begin
        if (flush_or_rst) begin
            state <= CFG_IDLE;
        end else begin
            case (state)
                CFG_IDLE:      if (cfg_req) state <= CFG_ACKED;
                CFG_ACKED:     state <= cfg_req ? CFG_WAIT_DROP : CFG_IDLE;
                CFG_WAIT_DROP: if (!cfg_req) state <= CFG_IDLE;
                default:       state <= CFG_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Registers and one-cycle strobes
    always_ff @(posedge clk) begin
        if (flush_or_rst) begin
            hold        <= 1'b0;
            redirect    <= 1'b0;
            scratch_we  <= 1'b0;
            scratch_idx <= '0;
        end else begin
            redirect   <= do_write && (cfg_addr == fetch_pkg::CFG_REDIRECT);
            scratch_we <= do_write && (cfg_addr == fetch_pkg::CFG_SCRATCH_DATA);
            if (do_write && cfg_addr == fetch_pkg::CFG_HOLD)
                hold <= cfg_wdata[0];
            // Data writes step the index so the memory loads as a stream
            if (do_write && cfg_addr == fetch_pkg::CFG_SCRATCH_ADDR)
                scratch_idx <= cfg_wdata[IDX_W-1:0];
            else if (do_write && cfg_addr == fetch_pkg::CFG_SCRATCH_DATA)
                scratch_idx <= scratch_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_write && cfg_addr == fetch_pkg::CFG_REDIRECT)
            redirect_pc <= cfg_wdata;
        if (do_write && cfg_addr == fetch_pkg::CFG_SCRATCH_DATA) begin
            scratch_waddr <= scratch_idx;
            scratch_wdata <= cfg_wdata;
        end
    end

    ack_needs_req: assert property (@(posedge clk) disable iff (flush_or_rst)
        $rose(cfg_ack) |-> $past(cfg_req))
        else $error("cfg_ack rose without cfg_req");

endmodule

// ==== src/bus_fetch_unit.sv ====
`timescale 1ns/1ps

module bus_fetch_unit (
    input  logic              clk,
    input  logic              flush_or_rst,

    // Fetch side
    input  logic              new_request,
    input  fetch_pkg::addr_t  addr,
    output logic              ready,
    output logic              data_valid,
    output fetch_pkg::instr_t data,

    // External memory, four-phase req/ack
    output logic              mem_req,
    output fetch_pkg::addr_t  mem_addr,
    input  logic              mem_ack,
    input  fetch_pkg::instr_t mem_rdata
);

    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_REQUESTING,
        BUS_RELEASING
    } bus_state_t;

    bus_state_t state;
    logic       discard;

    ////////////////////////////////////////////////////////////
    // Handshake
    // An open handshake always runs to completion, even across a flush
    always_ff @(posedge clk) begin
        case (state)
            BUS_IDLE:       if (new_request) state <= BUS_REQUESTING;
            BUS_REQUESTING: if (mem_ack) state <= BUS_RELEASING;
            BUS_RELEASING:  if (!mem_ack) state <= BUS_IDLE;
            default:        state <= BUS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == BUS_IDLE && new_request)
            mem_addr <= addr;
    end

    assign mem_req = (state == BUS_REQUESTING);
    assign ready   = (state == BUS_IDLE);

    ////////////////////////////////////////////////////////////
    // Return path
    // Data of a request older than the last flush is dropped
    always_ff @(posedge clk) begin
        if (flush_or_rst)
            discard <= 1'b1;
        else if (state == BUS_IDLE && new_request)
            discard <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (state == BUS_REQUESTING && mem_ack)
            data <= mem_rdata;
    end

    always_ff @(posedge clk) begin
        data_valid <= (state == BUS_REQUESTING) & mem_ack & ~discard & ~flush_or_rst;
    end

    mem_addr_stable: assert property (@(posedge clk) disable iff (flush_or_rst)
        (mem_req && $past(mem_req)) |-> (mem_addr == $past(mem_addr)))
        else $error("mem_addr changed during an open request");

endmodule

// ==== src/scratch_fetch_unit.sv ====
`timescale 1ns/1ps

module scratch_fetch_unit #(
    parameter int SCRATCH_WORDS = 256
) (
    input  logic                             clk,
    input  logic                             flush_or_rst,

    // Fetch side
    input  logic                             new_request,
    input  fetch_pkg::addr_t                 addr,
    output logic                             ready,
    output logic                             data_valid,
    output fetch_pkg::instr_t                data,

    // Loading from the configuration block
    input  logic                             scratch_we,
    input  logic [$clog2(SCRATCH_WORDS)-1:0] scratch_waddr,
    input  fetch_pkg::instr_t                scratch_wdata
);

    localparam int IDX_W = $clog2(SCRATCH_WORDS);

    fetch_pkg::instr_t words [SCRATCH_WORDS];
    logic [IDX_W-1:0]  read_idx;

    // Word index, byte offset dropped
    assign read_idx = addr[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (scratch_we)
            words[scratch_waddr] <= scratch_wdata;
    end

    // One registered read per request
    always_ff @(posedge clk) begin
        if (new_request)
            data <= words[read_idx];
    end

    // Flush kills the answer of a request made in the same cycle
    always_ff @(posedge clk) begin
        data_valid <= new_request & ~flush_or_rst;
    end

    assign ready = 1'b1;

endmodule

// ==== src/fetch_attr_fifo.sv ====
`timescale 1ns/1ps

module fetch_attr_fifo #(
    parameter int DATA_WIDTH = 34,
    parameter int DEPTH      = 2
) (
    input  logic                  clk,
    input  logic                  flush_or_rst,
    input  logic                  push,
    input  logic                  pop,
    input  logic [DATA_WIDTH-1:0] data_in,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  valid,
    output logic                  full
);

    localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_W = $clog2(DEPTH + 1);

    logic [DATA_WIDTH-1:0] entries [DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [COUNT_W-1:0]    count;

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk) begin
        if (flush_or_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            entries[wr_ptr] <= data_in;
    end

    assign data_out = entries[rd_ptr];
    assign valid    = (count != '0);
    assign full     = (count == COUNT_W'(DEPTH));

    no_overflow_or_underflow: assert property (@(posedge clk) disable iff (flush_or_rst)
        (push |-> !full) and (pop |-> valid))
        else $error("Attribute FIFO push while full or pop while empty");

endmodule

// ==== src/fetch_pkg.sv ====
package fetch_pkg;

    ////////////////////////////////////////////////////////////
    // Widths that carry a meaning
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [0:0]  unit_id_t;
    typedef logic [1:0]  cfg_addr_t;

    // Sub-unit indices, also used as FIFO attribute values
    localparam unit_id_t SCRATCH_ID = 1'b0;
    localparam unit_id_t BUS_ID     = 1'b1;

    ////////////////////////////////////////////////////////////
    // Address map

    // First fetch after reset lands in scratch
    localparam addr_t RESET_VEC = 32'h8000_0000;

    // Scratch region is one 4 KB page
    localparam addr_t SCRATCH_BASE       = 32'h8000_0000;
    localparam int    SCRATCH_CHECK_BITS = 20;

    // External memory takes a 256 MB window
    localparam addr_t MEMORY_BASE       = 32'h4000_0000;
    localparam int    MEMORY_CHECK_BITS = 4;

    ////////////////////////////////////////////////////////////
    // Configuration register indices
    localparam cfg_addr_t CFG_HOLD         = 2'd0;
    localparam cfg_addr_t CFG_REDIRECT     = 2'd1;
    localparam cfg_addr_t CFG_SCRATCH_ADDR = 2'd2;
    localparam cfg_addr_t CFG_SCRATCH_DATA = 2'd3;

endpackage
